//--- flist.f
logic/gpuSetupPkg.sv
logic/bboxClipper.sv
logic/edgeEvaluator.sv
logic/pixelWindowTest.sv
logic/lineStepper.sv
logic/gpuSetupTop.sv
dv/gpuSetup_sva.sv
dv/gpuSetupTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the gpuSetupTop testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module gpuSetupTb -f flist.f

status=0
./obj_dir/VgpuSetupTb 2>&1 | tee sim.log || status=$?

if grep -q "TB FAILED" sim.log || [ "$status" -ne 0 ]; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation finished without errors"

//--- dv/gpuSetupTb.sv
`timescale 1ns/1ns
`default_nettype none

module gpuSetupTb;

	// ------------------------------
	// Run length
	// ------------------------------

	localparam int ClkPeriod     = 100;
	localparam int NumDirected   = 7;
	localparam int NumRandReject = 100;
	localparam int NumRandTri    = 60;
	localparam int PixPerTri     = 4;
	localparam int NumLines      = 24;
	localparam int MaxLineLen    = 60;
	// Every test is bounded by the longest line walk
	localparam int NumTests      = NumDirected + NumRandReject
		+ NumRandTri * 2 * PixPerTri + NumLines;
	localparam int TimeoutCycles = NumTests * (MaxLineLen + 4) + 100;

	// DUT inputs
	logic                   i_clk;
	logic                   i_arstN;
	gpuSetupPkg::coordT     i_x0;
	gpuSetupPkg::coordT     i_y0;
	gpuSetupPkg::coordT     i_x1;
	gpuSetupPkg::coordT     i_y1;
	gpuSetupPkg::coordT     i_x2;
	gpuSetupPkg::coordT     i_y2;
	gpuSetupPkg::drawCoordT i_drawX0;
	gpuSetupPkg::drawCoordT i_drawY0;
	gpuSetupPkg::drawCoordT i_drawX1;
	gpuSetupPkg::drawCoordT i_drawY1;
	gpuSetupPkg::coordT     i_pixelX;
	gpuSetupPkg::coordT     i_pixelY;
	logic                   i_lineStart;
	logic                   i_loadNext;
	// DUT outputs
	logic                   o_earlyTriangleReject;
	logic                   o_earlyLineReject;
	gpuSetupPkg::coordT     o_minTriX;
	gpuSetupPkg::coordT     o_maxTriX;
	gpuSetupPkg::coordT     o_minTriY;
	gpuSetupPkg::coordT     o_maxTriY;
	logic                   o_validPixelL;
	logic                   o_validPixelR;
	logic                   o_lineInsideDrawArea;
	gpuSetupPkg::coordT     o_nextLineX;
	gpuSetupPkg::coordT     o_nextLineY;

	// Drawing area of the current test
	int areaX0;
	int areaY0;
	int areaX1;
	int areaY1;
	logic [31:0] rngState = 32'h63f4_8c6b;

	gpuSetupTop gpuSetupTop_i (.*);

	initial begin
		i_clk = 1'b0;
		forever #(ClkPeriod / 2) i_clk = ~i_clk;
	end

	// ------------------------------
	// Helpers
	// ------------------------------

	// LCG step, value spread over lo..hi
	function automatic int randRange(input int lo, input int hi);
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return lo + int'((rngState >> 8) % 32'(hi - lo + 1));
	endfunction

	function automatic int lower(input int a, input int b);
		return (a < b) ? a : b;
	endfunction

	function automatic int upper(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	// Edge a->b at a pixel, one less on top-left edges
	function automatic int edgeValue(input int xa, input int ya, input int xb, input int yb,
		input int px, input int py);
		int bias;
		bias = ((ya - yb) < 0 || ((ya == yb) && (xb - xa) < 0)) ? -1 : 0;
		return (xb - xa) * (py - ya) - (yb - ya) * (px - xa) + bias;
	endfunction

	// Inside for either winding when all three signs agree
	function automatic bit insideTri(input int px, input int py);
		int w0;
		int w1;
		int w2;
		w0 = edgeValue(int'(i_x1), int'(i_y1), int'(i_x2), int'(i_y2), px, py);
		w1 = edgeValue(int'(i_x2), int'(i_y2), int'(i_x0), int'(i_y0), px, py);
		w2 = edgeValue(int'(i_x0), int'(i_y0), int'(i_x1), int'(i_y1), px, py);
		return (w0 >= 0 && w1 >= 0 && w2 >= 0) || (w0 < 0 && w1 < 0 && w2 < 0);
	endfunction

	task automatic checkValue(input string name, input int expVal, input int actVal);
		assert (expVal == actVal) else begin
			$display("CHECK FAILED at %0t ns: %s expected %0d actual %0d",
				$time, name, expVal, actVal);
			$display("TB FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// ------------------------------
	// Setup reference
	// ------------------------------

	task automatic checkSetup(input bit withPixels);
		int minX;
		int maxX;
		int minY;
		int maxY;
		int clMinX;
		int clMaxX;
		int clMinY;
		int clMaxY;
		int px;
		int py;
		int pxL;
		bit spanBig;
		bit triRej;
		bit lineRej;
		bit rowIn;
		minX = lower(lower(int'(i_x0), int'(i_x1)), int'(i_x2));
		maxX = upper(upper(int'(i_x0), int'(i_x1)), int'(i_x2));
		minY = lower(lower(int'(i_y0), int'(i_y1)), int'(i_y2));
		maxY = upper(upper(int'(i_y0), int'(i_y1)), int'(i_y2));
		spanBig = (maxX - minX >= gpuSetupPkg::MAX_SPAN_X)
			|| (maxY - minY >= gpuSetupPkg::MAX_SPAN_Y);
		triRej = spanBig || maxX < areaX0 || minX > areaX1 || maxY < areaY0 || minY > areaY1;
		// Line box uses vertex 0 and 1 only, span still from the triangle
		lineRej = spanBig
			|| upper(int'(i_x0), int'(i_x1)) < areaX0 || lower(int'(i_x0), int'(i_x1)) > areaX1
			|| upper(int'(i_y0), int'(i_y1)) < areaY0 || lower(int'(i_y0), int'(i_y1)) > areaY1;
		checkValue("o_earlyTriangleReject", int'(triRej), int'(o_earlyTriangleReject));
		checkValue("o_earlyLineReject", int'(lineRej), int'(o_earlyLineReject));
		// Lower bounds raised, upper bounds replaced at or past the end
		clMinX = (minX < areaX0) ? areaX0 : minX;
		clMaxX = (maxX >= areaX1) ? areaX1 : maxX;
		clMinY = (minY < areaY0) ? areaY0 : minY;
		clMaxY = (maxY >= areaY1) ? areaY1 : maxY;
		if (!triRej) begin
			checkValue("o_minTriX", clMinX, int'(o_minTriX));
			checkValue("o_maxTriX", clMaxX, int'(o_maxTriX));
			checkValue("o_minTriY", clMinY, int'(o_minTriY));
			checkValue("o_maxTriY", clMaxY, int'(o_maxTriY));
		end
		px = int'(i_pixelX);
		py = int'(i_pixelY);
		pxL = px - (px & 1);
		rowIn = py >= clMinY && py <= clMaxY;
		if (withPixels) begin
			checkValue("o_validPixelL", int'(rowIn && pxL >= clMinX && pxL <= clMaxX
				&& insideTri(pxL, py)), int'(o_validPixelL));
			checkValue("o_validPixelR", int'(rowIn && pxL + 1 >= clMinX && pxL + 1 <= clMaxX
				&& insideTri(pxL + 1, py)), int'(o_validPixelR));
		end
		// Line pixel itself, bottom row of the area left out
		checkValue("o_lineInsideDrawArea", int'(py >= areaY0 && py < areaY1
			&& px >= areaX0 && px <= areaX1), int'(o_lineInsideDrawArea));
	endtask

	task automatic applyTriangle(input int x0, input int y0, input int x1, input int y1,
		input int x2, input int y2, input int px, input int py, input bit withPixels);
		@(negedge i_clk);
		i_x0 = gpuSetupPkg::coordT'(x0);
		i_y0 = gpuSetupPkg::coordT'(y0);
		i_x1 = gpuSetupPkg::coordT'(x1);
		i_y1 = gpuSetupPkg::coordT'(y1);
		i_x2 = gpuSetupPkg::coordT'(x2);
		i_y2 = gpuSetupPkg::coordT'(y2);
		i_drawX0 = gpuSetupPkg::drawCoordT'(areaX0);
		i_drawY0 = gpuSetupPkg::drawCoordT'(areaY0);
		i_drawX1 = gpuSetupPkg::drawCoordT'(areaX1);
		i_drawY1 = gpuSetupPkg::drawCoordT'(areaY1);
		i_pixelX = gpuSetupPkg::coordT'(px);
		i_pixelY = gpuSetupPkg::coordT'(py);
		@(posedge i_clk);
		checkSetup(withPixels);
	endtask

	// Random area that always has start <= end
	task automatic pickArea();
		areaX0 = randRange(0, 400);
		areaX1 = randRange(areaX0, 1023);
		areaY0 = randRange(0, 300);
		areaY1 = randRange(areaY0, 511);
	endtask

	// ------------------------------
	// Line walk with fed back pixel
	// ------------------------------

	task automatic runLine(input int x0, input int y0, input int x1, input int y1);
		int sx;
		int sy;
		int majorD;
		int minorD;
		int refErr;
		int expX;
		int expY;
		bit swapAxis;
		bit chg;
		sx = (x1 < x0) ? -1 : 1;
		sy = (y1 < y0) ? -1 : 1;
		swapAxis = (y1 - y0) * sy > (x1 - x0) * sx;
		majorD = swapAxis ? (y1 - y0) * sy : (x1 - x0) * sx;
		minorD = swapAxis ? (x1 - x0) * sx : (y1 - y0) * sy;
		refErr = 2 * minorD + (swapAxis ? 0 : 1);
		@(negedge i_clk);
		i_x0 = gpuSetupPkg::coordT'(x0);
		i_y0 = gpuSetupPkg::coordT'(y0);
		i_x1 = gpuSetupPkg::coordT'(x1);
		i_y1 = gpuSetupPkg::coordT'(y1);
		i_pixelX = i_x0;
		i_pixelY = i_y0;
		i_lineStart = 1'b1;
		for (int k = 0; k < majorD; k++) begin
			@(negedge i_clk);
			i_lineStart = 1'b0;
			// Major axis every step, minor on a direction change
			chg = refErr > majorD;
			expX = int'(i_pixelX) + ((!swapAxis || chg) ? sx : 0);
			expY = int'(i_pixelY) + ((swapAxis || chg) ? sy : 0);
			refErr = refErr + 2 * minorD - (chg ? 2 * majorD : 0);
			checkValue("o_nextLineX", expX, int'(o_nextLineX));
			checkValue("o_nextLineY", expY, int'(o_nextLineY));
			i_pixelX = o_nextLineX;
			i_pixelY = o_nextLineY;
			i_loadNext = 1'b1;
		end
		@(negedge i_clk);
		i_lineStart = 1'b0;
		i_loadNext = 1'b0;
		checkValue("i_pixelX at line end", x1, int'(i_pixelX));
		checkValue("i_pixelY at line end", y1, int'(i_pixelY));
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------

	initial begin
		int bx;
		int by;
		int vx[3];
		int vy[3];
		int ia;
		int ib;
		int lx;
		int ly;
		i_arstN = 1'b1;
		i_x0 = '0;
		i_y0 = '0;
		i_x1 = '0;
		i_y1 = '0;
		i_x2 = '0;
		i_y2 = '0;
		i_drawX0 = '0;
		i_drawY0 = '0;
		i_drawX1 = '0;
		i_drawY1 = '0;
		i_pixelX = '0;
		i_pixelY = '0;
		i_lineStart = 1'b0;
		i_loadNext = 1'b0;
		#10;
		i_arstN = 1'b0;
		repeat (5) @(posedge i_clk);
		@(negedge i_clk);
		i_arstN = 1'b1;
		// Right, left, above, below, too wide, too tall, then a corner hit
		areaX0 = 100;
		areaX1 = 700;
		areaY0 = 50;
		areaY1 = 400;
		applyTriangle(720, 100, 800, 200, 750, 300, 720, 100, 1'b1);
		applyTriangle(10, 100, 90, 200, 50, 300, 51, 150, 1'b1);
		applyTriangle(200, 0, 300, 49, 250, 20, 250, 20, 1'b1);
		applyTriangle(200, 401, 300, 450, 250, 500, 260, 440, 1'b1);
		applyTriangle(0, 100, 1100, 200, 500, 300, 500, 200, 1'b1);
		applyTriangle(200, 0, 300, 520, 250, 100, 250, 100, 1'b1);
		applyTriangle(700, 400, 650, 350, 690, 380, 689, 380, 1'b1);
		// Full range vertices, box rules only
		for (int t = 0; t < NumRandReject; t++) begin
			pickArea();
			applyTriangle(randRange(-2048, 2047), randRange(-2048, 2047),
				randRange(-2048, 2047), randRange(-2048, 2047),
				randRange(-2048, 2047), randRange(-2048, 2047),
				randRange(-2048, 2047), randRange(-2048, 2047), 1'b0);
		end
		// Bounded triangles in both windings, pixels around the box
		for (int t = 0; t < NumRandTri; t++) begin
			pickArea();
			bx = randRange(-100, 1000);
			by = randRange(-60, 500);
			for (int v = 0; v < 3; v++) begin
				vx[v] = bx + randRange(-300, 300);
				vy[v] = by + randRange(-150, 150);
			end
			for (int w = 0; w < 2; w++) begin
				ia = (w == 0) ? 1 : 2;
				ib = (w == 0) ? 2 : 1;
				for (int p = 0; p < PixPerTri; p++) begin
					lx = randRange(lower(lower(vx[0], vx[1]), vx[2]) - 3,
						upper(upper(vx[0], vx[1]), vx[2]) + 3);
					ly = randRange(lower(lower(vy[0], vy[1]), vy[2]) - 3,
						upper(upper(vy[0], vy[1]), vy[2]) + 3);
					applyTriangle(vx[0], vy[0], vx[ia], vy[ia], vx[ib], vy[ib], lx, ly, 1'b1);
				end
			end
		end
		// Lines of every octant up to the longest length
		for (int n = 0; n < NumLines; n++) begin
			lx = randRange(100, 800);
			ly = randRange(50, 400);
			runLine(lx, ly, lx + randRange(-MaxLineLen, MaxLineLen),
				ly + randRange(-MaxLineLen, MaxLineLen));
		end
		@(negedge i_clk);
		$display("TB PASSED");
		$finish;
	end

	// Watchdog
	initial begin
		#(TimeoutCycles * ClkPeriod);
		$display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- dv/gpuSetup_sva.sv
`timescale 1ns/1ns
`default_nettype none

module gpuSetupSva (
	input logic                 i_clk,
	input logic                 i_arstN,
	input gpuSetupPkg::coordT   i_pixelX,
	input gpuSetupPkg::coordT   i_pixelY,
	input logic                 i_loadNext,
	input gpuSetupPkg::coordT   o_nextLineX,
	input gpuSetupPkg::coordT   o_nextLineY,
	input logic                 o_validPixelL,
	input logic                 o_earlyTriangleReject,
	input gpuSetupPkg::coordT   o_minTriX,
	input gpuSetupPkg::coordT   o_maxTriX,
	input gpuSetupPkg::coordT   o_minTriY,
	input gpuSetupPkg::coordT   o_maxTriY,
	input gpuSetupPkg::lineErrT lineErr
);

	// Step size per axis and even pixel of the pair
	gpuSetupPkg::coordT stepX;
	gpuSetupPkg::coordT stepY;
	gpuSetupPkg::coordT pixL;

	assign stepX = o_nextLineX - i_pixelX;
	assign stepY = o_nextLineY - i_pixelY;
	assign pixL  = {i_pixelX[11:1], 1'b0};

	// ------------------------------
	// Line stepper
	// ------------------------------

	// Error register held clear in reset
	assert property (@(posedge i_clk) !i_arstN |-> (lineErr == '0))
		else $error("line error term not zero during reset");

	// One pixel at most per axis
	assert property (@(posedge i_clk) disable iff (!i_arstN)
		i_loadNext |-> (stepX >= -12'sd1) && (stepX <= 12'sd1)
			&& (stepY >= -12'sd1) && (stepY <= 12'sd1))
		else $error("line step moved an axis by more than one pixel");

	// ------------------------------
	// Triangle box
	// ------------------------------

	// Valid left pixel lies in the clipped box
	assert property (@(posedge i_clk) disable iff (!i_arstN)
		o_validPixelL |-> (pixL >= o_minTriX) && (pixL <= o_maxTriX)
			&& (i_pixelY >= o_minTriY) && (i_pixelY <= o_maxTriY))
		else $error("left pixel valid outside the clipped box");

	// Accepted box never inverted
	assert property (@(posedge i_clk) disable iff (!i_arstN)
		!o_earlyTriangleReject |-> (o_minTriX <= o_maxTriX) && (o_minTriY <= o_maxTriY))
		else $error("clipped box minimum above maximum");

endmodule

bind gpuSetupTop gpuSetupSva gpuSetupSva_i (
	.i_clk (i_clk), .i_arstN (i_arstN),
	.i_pixelX (i_pixelX), .i_pixelY (i_pixelY), .i_loadNext (i_loadNext),
	.o_nextLineX (o_nextLineX), .o_nextLineY (o_nextLineY),
	.o_validPixelL (o_validPixelL), .o_earlyTriangleReject (o_earlyTriangleReject),
	.o_minTriX (o_minTriX), .o_maxTriX (o_maxTriX),
	.o_minTriY (o_minTriY), .o_maxTriY (o_maxTriY),
	.lineErr (lineStepper_i.lineErr)
);

`default_nettype wire

//--- logic/gpuSetupTop.sv
`timescale 1ns/1ns
`default_nettype none

module gpuSetupTop #(
	parameter int pMaxSpanX = gpuSetupPkg::MAX_SPAN_X,
	parameter int pMaxSpanY = gpuSetupPkg::MAX_SPAN_Y
) (
	input  logic                   i_clk,
	input  logic                   i_arstN,
	input  gpuSetupPkg::coordT     i_x0,
	input  gpuSetupPkg::coordT     i_y0,
	input  gpuSetupPkg::coordT     i_x1,
	input  gpuSetupPkg::coordT     i_y1,
	input  gpuSetupPkg::coordT     i_x2,
	input  gpuSetupPkg::coordT     i_y2,
	input  gpuSetupPkg::drawCoordT i_drawX0,
	input  gpuSetupPkg::drawCoordT i_drawY0,
	input  gpuSetupPkg::drawCoordT i_drawX1,
	input  gpuSetupPkg::drawCoordT i_drawY1,
	input  gpuSetupPkg::coordT     i_pixelX,
	input  gpuSetupPkg::coordT     i_pixelY,
	input  logic                   i_lineStart,
	input  logic                   i_loadNext,
	output logic                   o_earlyTriangleReject,
	output logic                   o_earlyLineReject,
	output gpuSetupPkg::coordT     o_minTriX,
	output gpuSetupPkg::coordT     o_maxTriX,
	output gpuSetupPkg::coordT     o_minTriY,
	output gpuSetupPkg::coordT     o_maxTriY,
	output logic                   o_validPixelL,
	output logic                   o_validPixelR,
	output logic                   o_lineInsideDrawArea,
	output gpuSetupPkg::coordT     o_nextLineX,
	output gpuSetupPkg::coordT     o_nextLineY
);

	// Clipped triangle box, shared by the box outputs and the pair test
	gpuSetupPkg::coordT minX;
	gpuSetupPkg::coordT maxX;
	gpuSetupPkg::coordT minY;
	gpuSetupPkg::coordT maxY;
	// Edge side result per pixel of the pair
	logic insideL;
	logic insideR;

	// ------------------------------
	// Primitive setup
	// ------------------------------

	bboxClipper #(
		.pMaxSpanX (pMaxSpanX),
		.pMaxSpanY (pMaxSpanY)
	) bboxClipper_i (
		.i_x0 (i_x0), .i_y0 (i_y0),
		.i_x1 (i_x1), .i_y1 (i_y1),
		.i_x2 (i_x2), .i_y2 (i_y2),
		.i_drawX0 (i_drawX0), .i_drawY0 (i_drawY0),
		.i_drawX1 (i_drawX1), .i_drawY1 (i_drawY1),
		.o_minX (minX), .o_maxX (maxX),
		.o_minY (minY), .o_maxY (maxY),
		.o_triReject (o_earlyTriangleReject),
		.o_lineReject (o_earlyLineReject)
	);

	assign o_minTriX = minX;
	assign o_maxTriX = maxX;
	assign o_minTriY = minY;
	assign o_maxTriY = maxY;

	// ------------------------------
	// Per pixel tests
	// ------------------------------

	edgeEvaluator edgeEvaluator_i (
		.i_x0 (i_x0), .i_y0 (i_y0),
		.i_x1 (i_x1), .i_y1 (i_y1),
		.i_x2 (i_x2), .i_y2 (i_y2),
		.i_pixelX (i_pixelX), .i_pixelY (i_pixelY),
		.o_insideL (insideL), .o_insideR (insideR)
	);

	pixelWindowTest pixelWindowTest_i (
		.i_pixelX (i_pixelX), .i_pixelY (i_pixelY),
		.i_drawX0 (i_drawX0), .i_drawY0 (i_drawY0),
		.i_drawX1 (i_drawX1), .i_drawY1 (i_drawY1),
		.i_minX (minX), .i_maxX (maxX),
		.i_minY (minY), .i_maxY (maxY),
		.i_insideL (insideL), .i_insideR (insideR),
		.o_validPixelL (o_validPixelL),
		.o_validPixelR (o_validPixelR),
		.o_lineInsideDrawArea (o_lineInsideDrawArea)
	);

	// Line walk, next pixel is fed back by the scanner
	lineStepper lineStepper_i (
		.i_clk (i_clk), .i_arstN (i_arstN),
		.i_x0 (i_x0), .i_y0 (i_y0),
		.i_x1 (i_x1), .i_y1 (i_y1),
		.i_pixelX (i_pixelX), .i_pixelY (i_pixelY),
		.i_lineStart (i_lineStart), .i_loadNext (i_loadNext),
		.o_nextX (o_nextLineX), .o_nextY (o_nextLineY)
	);

endmodule

`default_nettype wire

//--- logic/lineStepper.sv
`timescale 1ns/1ns
`default_nettype none

module lineStepper (
	input  logic               i_clk,
	input  logic               i_arstN,
	input  gpuSetupPkg::coordT i_x0,
	input  gpuSetupPkg::coordT i_y0,
	input  gpuSetupPkg::coordT i_x1,
	input  gpuSetupPkg::coordT i_y1,
	input  gpuSetupPkg::coordT i_pixelX,
	input  gpuSetupPkg::coordT i_pixelY,
	input  logic               i_lineStart,
	input  logic               i_loadNext,
	output gpuSetupPkg::coordT o_nextX,
	output gpuSetupPkg::coordT o_nextY
);

	// ------------------------------
	// Axis setup
	// ------------------------------

	logic signed [12:0] deltaX;
	logic signed [12:0] deltaY;
	logic               negXAxis;
	logic               negYAxis;
	logic [11:0]        absX;
	logic [11:0]        absY;
	logic               swapAxis;
	logic [11:0]        majorD;
	logic [11:0]        minorD;
	gpuSetupPkg::lineErrT initErr;

	assign deltaX   = {i_x1[11], i_x1} - {i_x0[11], i_x0};
	assign deltaY   = {i_y1[11], i_y1} - {i_y0[11], i_y0};
	assign negXAxis = deltaX[12];
	assign negYAxis = deltaY[12];
	assign absX     = negXAxis ? 12'(-deltaX) : deltaX[11:0];
	assign absY     = negYAxis ? 12'(-deltaY) : deltaY[11:0];

	// Y becomes the major axis on steep lines
	assign swapAxis = absY > absX;
	assign majorD   = swapAxis ? absY : absX;
	assign minorD   = swapAxis ? absX : absY;

	// 2*minor, plus one on shallow lines
	assign initErr = {1'b0, minorD, !swapAxis};

	// ------------------------------
	// Error register
	// ------------------------------

	gpuSetupPkg::lineErrT lineErr;
	gpuSetupPkg::lineErrT errIncr;
	logic                 changeDir;

	assign changeDir = lineErr > $signed({2'b00, majorD});

	// +2*minor every step, -2*major when the minor axis moves
	assign errIncr = {1'b0, minorD, 1'b0} - (changeDir ? {1'b0, majorD, 1'b0} : 14'd0);

	// Start has priority over a step in the same cycle
	always_ff @(posedge i_clk or negedge i_arstN) begin
		if (!i_arstN) begin
			lineErr <= '0;
		end else if (i_lineStart) begin
			lineErr <= initErr;
		end else if (i_loadNext) begin
			lineErr <= lineErr + errIncr;
		end
	end

	// ------------------------------
	// Next pixel
	// ------------------------------

	logic               stepXEn;
	logic               stepYEn;
	gpuSetupPkg::coordT incrX;
	gpuSetupPkg::coordT incrY;

	// Major axis always moves
	assign stepXEn = !swapAxis | changeDir;
	assign stepYEn =  swapAxis | changeDir;

	assign incrX = stepXEn ? (negXAxis ? -12'sd1 : 12'sd1) : 12'sd0;
	assign incrY = stepYEn ? (negYAxis ? -12'sd1 : 12'sd1) : 12'sd0;

	assign o_nextX = i_pixelX + incrX;
	assign o_nextY = i_pixelY + incrY;

endmodule

`default_nettype wire

//--- logic/pixelWindowTest.sv
`timescale 1ns/1ns
`default_nettype none

module pixelWindowTest (
	input  gpuSetupPkg::coordT     i_pixelX,
	input  gpuSetupPkg::coordT     i_pixelY,
	input  gpuSetupPkg::drawCoordT i_drawX0,
	input  gpuSetupPkg::drawCoordT i_drawY0,
	input  gpuSetupPkg::drawCoordT i_drawX1,
	input  gpuSetupPkg::drawCoordT i_drawY1,
	input  gpuSetupPkg::coordT     i_minX,
	input  gpuSetupPkg::coordT     i_maxX,
	input  gpuSetupPkg::coordT     i_minY,
	input  gpuSetupPkg::coordT     i_maxY,
	input  logic                   i_insideL,
	input  logic                   i_insideR,
	output logic                   o_validPixelL,
	output logic                   o_validPixelR,
	output logic                   o_lineInsideDrawArea
);

	// Even and odd pixel of the current pair
	gpuSetupPkg::coordT pixL;
	gpuSetupPkg::coordT pixR;

	assign pixL = gpuSetupPkg::pairLeft(i_pixelX);
	assign pixR = {i_pixelX[11:1], 1'b1};

	// ------------------------------
	// Triangle pair vs clipped box
	// ------------------------------

	logic rowInBox;
	logic pixLInBox;
	logic pixRInBox;

	// Both box edges inclusive
	assign rowInBox  = (i_pixelY >= i_minY) & (i_pixelY <= i_maxY);
	assign pixLInBox = rowInBox & (pixL >= i_minX) & (pixL <= i_maxX);
	assign pixRInBox = rowInBox & (pixR >= i_minX) & (pixR <= i_maxX);

	assign o_validPixelL = pixLInBox & i_insideL;
	assign o_validPixelR = pixRInBox & i_insideR;

	// ------------------------------
	// Line pixel vs draw area
	// ------------------------------

	gpuSetupPkg::coordT areaX0;
	gpuSetupPkg::coordT areaY0;
	gpuSetupPkg::coordT areaX1;
	gpuSetupPkg::coordT areaY1;
	logic               rowInArea;
	logic               lineLeftPix;
	logic               lineRightPix;

	assign areaX0 = gpuSetupPkg::extArea(i_drawX0);
	assign areaY0 = gpuSetupPkg::extArea(i_drawY0);
	assign areaX1 = gpuSetupPkg::extArea(i_drawX1);
	assign areaY1 = gpuSetupPkg::extArea(i_drawY1);

	// Bottom row of the area excluded for lines
	assign rowInArea = (i_pixelY >= areaY0) & (i_pixelY < areaY1);

	// Bit 0 picks which half of the pair is the line pixel
	assign lineLeftPix  = !i_pixelX[0] & (pixL >= areaX0) & (pixL <= areaX1);
	assign lineRightPix =  i_pixelX[0] & (pixR >= areaX0) & (pixR <= areaX1);

	assign o_lineInsideDrawArea = rowInArea & (lineLeftPix | lineRightPix);

endmodule

`default_nettype wire

//--- logic/edgeEvaluator.sv
`timescale 1ns/1ns
`default_nettype none

module edgeEvaluator (
	input  gpuSetupPkg::coordT i_x0,
	input  gpuSetupPkg::coordT i_y0,
	input  gpuSetupPkg::coordT i_x1,
	input  gpuSetupPkg::coordT i_y1,
	input  gpuSetupPkg::coordT i_x2,
	input  gpuSetupPkg::coordT i_y2,
	input  gpuSetupPkg::coordT i_pixelX,
	input  gpuSetupPkg::coordT i_pixelY,
	output logic               o_insideL,
	output logic               o_insideR
);

	localparam int EdgeMsb = $bits(gpuSetupPkg::edgeT) - 1;

	// Top-left rule
	// X coefficient negative, or zero with a negative Y coefficient
	function automatic logic isTopLeft(
		input gpuSetupPkg::coordT coefX,
		input gpuSetupPkg::coordT coefY
	);
		return coefX[11] | ((coefX == '0) & coefY[11]);
	endfunction

	// One edge function at a pixel, bias of -1 on top-left edges
	function automatic gpuSetupPkg::edgeT edgeAt(
		input gpuSetupPkg::coordT coefY,
		input gpuSetupPkg::coordT coefX,
		input gpuSetupPkg::coordT distY,
		input gpuSetupPkg::coordT distX,
		input logic               topLeft
	);
		gpuSetupPkg::edgeT bias;
		bias = topLeft ? -23'sd1 : 23'sd0;
		return gpuSetupPkg::edgeT'(coefY) * gpuSetupPkg::edgeT'(distY)
			+ gpuSetupPkg::edgeT'(coefX) * gpuSetupPkg::edgeT'(distX) + bias;
	endfunction

	// Inside for either winding, all signs agree
	function automatic logic allSameSide(
		input gpuSetupPkg::edgeT w0,
		input gpuSetupPkg::edgeT w1,
		input gpuSetupPkg::edgeT w2
	);
		return !(w0[EdgeMsb] | w1[EdgeMsb] | w2[EdgeMsb])
			| (w0[EdgeMsb] & w1[EdgeMsb] & w2[EdgeMsb]);
	endfunction

	// ------------------------------
	// Edge coefficients
	// ------------------------------

	// Accepted triangles keep every delta inside 12 bits
	gpuSetupPkg::coordT dx21;
	gpuSetupPkg::coordT dy12;
	gpuSetupPkg::coordT dx02;
	gpuSetupPkg::coordT dy20;
	gpuSetupPkg::coordT dx10;
	gpuSetupPkg::coordT dy01;

	assign dx21 = i_x2 - i_x1;
	assign dy12 = i_y1 - i_y2;
	assign dx02 = i_x0 - i_x2;
	assign dy20 = i_y2 - i_y0;
	assign dx10 = i_x1 - i_x0;
	assign dy01 = i_y0 - i_y1;

	// ------------------------------
	// Pixel pair evaluation
	// ------------------------------

	gpuSetupPkg::coordT pixL;
	gpuSetupPkg::edgeT  w0L;
	gpuSetupPkg::edgeT  w1L;
	gpuSetupPkg::edgeT  w2L;
	gpuSetupPkg::edgeT  w0R;
	gpuSetupPkg::edgeT  w1R;
	gpuSetupPkg::edgeT  w2R;

	assign pixL = gpuSetupPkg::pairLeft(i_pixelX);

	// Edge v1->v2, edge v2->v0, edge v0->v1
	assign w0L = edgeAt(dx21, dy12, i_pixelY - i_y1, pixL - i_x1, isTopLeft(dy12, dx21));
	assign w1L = edgeAt(dx02, dy20, i_pixelY - i_y2, pixL - i_x2, isTopLeft(dy20, dx02));
	assign w2L = edgeAt(dx10, dy01, i_pixelY - i_y0, pixL - i_x0, isTopLeft(dy01, dx10));

	// Right pixel is one step in X
	assign w0R = w0L + gpuSetupPkg::edgeT'(dy12);
	assign w1R = w1L + gpuSetupPkg::edgeT'(dy20);
	assign w2R = w2L + gpuSetupPkg::edgeT'(dy01);

	assign o_insideL = allSameSide(w0L, w1L, w2L);
	assign o_insideR = allSameSide(w0R, w1R, w2R);

endmodule

`default_nettype wire

//--- logic/bboxClipper.sv
`timescale 1ns/1ns
`default_nettype none

module bboxClipper #(
	parameter int pMaxSpanX = gpuSetupPkg::MAX_SPAN_X,
	parameter int pMaxSpanY = gpuSetupPkg::MAX_SPAN_Y
) (
	input  gpuSetupPkg::coordT     i_x0,
	input  gpuSetupPkg::coordT     i_y0,
	input  gpuSetupPkg::coordT     i_x1,
	input  gpuSetupPkg::coordT     i_y1,
	input  gpuSetupPkg::coordT     i_x2,
	input  gpuSetupPkg::coordT     i_y2,
	input  gpuSetupPkg::drawCoordT i_drawX0,
	input  gpuSetupPkg::drawCoordT i_drawY0,
	input  gpuSetupPkg::drawCoordT i_drawX1,
	input  gpuSetupPkg::drawCoordT i_drawY1,
	output gpuSetupPkg::coordT     o_minX,
	output gpuSetupPkg::coordT     o_maxX,
	output gpuSetupPkg::coordT     o_minY,
	output gpuSetupPkg::coordT     o_maxY,
	output logic                   o_triReject,
	output logic                   o_lineReject
);

	// ------------------------------
	// Vertex 0/1 box
	// ------------------------------

	// Extra bit keeps the delta sign right over the whole vertex range
	logic signed [12:0] deltaX;
	logic signed [12:0] deltaY;
	gpuSetupPkg::coordT minX01;
	gpuSetupPkg::coordT maxX01;
	gpuSetupPkg::coordT minY01;
	gpuSetupPkg::coordT maxY01;

	assign deltaX = {i_x1[11], i_x1} - {i_x0[11], i_x0};
	assign deltaY = {i_y1[11], i_y1} - {i_y0[11], i_y0};

	// Negative delta means vertex 1 is the low corner
	assign minX01 = deltaX[12] ? i_x1 : i_x0;
	assign maxX01 = deltaX[12] ? i_x0 : i_x1;
	assign minY01 = deltaY[12] ? i_y1 : i_y0;
	assign maxY01 = deltaY[12] ? i_y0 : i_y1;

	// ------------------------------
	// Triangle box
	// ------------------------------

	gpuSetupPkg::coordT minTriX;
	gpuSetupPkg::coordT maxTriX;
	gpuSetupPkg::coordT minTriY;
	gpuSetupPkg::coordT maxTriY;

	// Grow the line box with vertex 2
	assign minTriX = (i_x2 < minX01) ? i_x2 : minX01;
	assign maxTriX = (i_x2 > maxX01) ? i_x2 : maxX01;
	assign minTriY = (i_y2 < minY01) ? i_y2 : minY01;
	assign maxTriY = (i_y2 > maxY01) ? i_y2 : maxY01;

	// Box size, always positive since max >= min
	logic [12:0] spanX;
	logic [12:0] spanY;
	logic        spanTooBig;

	assign spanX = {maxTriX[11], maxTriX} - {minTriX[11], minTriX};
	assign spanY = {maxTriY[11], maxTriY} - {minTriY[11], minTriY};
	assign spanTooBig = (spanX >= 13'(pMaxSpanX)) | (spanY >= 13'(pMaxSpanY));

	// ------------------------------
	// Draw area tests
	// ------------------------------

	gpuSetupPkg::coordT areaX0;
	gpuSetupPkg::coordT areaY0;
	gpuSetupPkg::coordT areaX1;
	gpuSetupPkg::coordT areaY1;

	assign areaX0 = gpuSetupPkg::extArea(i_drawX0);
	assign areaY0 = gpuSetupPkg::extArea(i_drawY0);
	assign areaX1 = gpuSetupPkg::extArea(i_drawX1);
	assign areaY1 = gpuSetupPkg::extArea(i_drawY1);

	// Area end is inclusive so the far side rejects only past it
	assign o_triReject = spanTooBig
		| (maxTriX < areaX0) | (minTriX > areaX1)
		| (maxTriY < areaY0) | (minTriY > areaY1);

	// Same outside rules on the vertex 0/1 box
	// span check still comes from the triangle box
	assign o_lineReject = spanTooBig
		| (maxX01 < areaX0) | (minX01 > areaX1)
		| (maxY01 < areaY0) | (minY01 > areaY1);

	// Clip to area, meaningful once the triangle is accepted
	assign o_minX = (minTriX < areaX0) ? areaX0 : minTriX;
	assign o_maxX = (maxTriX >= areaX1) ? areaX1 : maxTriX;
	assign o_minY = (minTriY < areaY0) ? areaY0 : minTriY;
	assign o_maxY = (maxTriY >= areaY1) ? areaY1 : maxTriY;

endmodule

`default_nettype wire

//--- logic/gpuSetupPkg.sv
`default_nettype none

package gpuSetupPkg;

	// ------------------------------
	// Datapath types
	// ------------------------------

	// Vertex and pixel position, two's complement
	typedef logic signed [11:0] coordT;

	// Drawing area register value, never negative
	typedef logic [9:0] drawCoordT;

	// Edge function result
	// Holds a 12x12 product sum plus the top-left bias, MSB is the side test
	typedef logic signed [22:0] edgeT;

	// Bresenham decision variable
	typedef logic signed [13:0] lineErrT;

	// ------------------------------
	// Primitive size limits
	// ------------------------------

	// Widest accepted box spans MAX_SPAN_X - 1
	localparam int MAX_SPAN_X = 1024;

	// Tallest accepted box spans MAX_SPAN_Y - 1
	localparam int MAX_SPAN_Y = 512;

	// ------------------------------
	// Shared helpers
	// ------------------------------

	// Draw area register seen as a signed coordinate
	function automatic coordT extArea(input drawCoordT v);
		return coordT'({2'b00, v});
	endfunction

	// Even pixel of the pair that holds x
	function automatic coordT pairLeft(input coordT x);
		return {x[11:1], 1'b0};
	endfunction

endpackage

`default_nettype wire
